// ==== design/cart_consts.svh ====
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// PRG RAM in four 16 KB banks
`define CART_PRG_BITS 16

// CHR RAM in four 8 KB banks
`define CART_CHR_BITS 15

`define CART_WRAM_BITS 13

`define CART_BANK_BITS 2

// Configuration register addresses
`define CART_CFG_MAPPER 4'd0
`define CART_CFG_LAUNCHER 4'd1

`define CART_RESET_VECTOR 16'hFFFC

`endif

// ==== design/cart_pkg.sv ====
package cart_pkg;

    // Mapper selected by the configuration port
    typedef enum logic [1:0] {
        MAP_LAUNCHER,
        MAP_NROM,
        MAP_UXROM,
        MAP_CNROM
    } mapper_kind_t;

    typedef enum logic {
        SPACE_CPU,
        SPACE_PPU
    } bus_space_t;

    // Memory region a request lands in after decode
    typedef enum logic [1:0] {
        REG_PRG,
        REG_WRAM,
        REG_CHR,
        REG_NONE
    } region_t;

    typedef struct packed {
        bus_space_t space;
        logic [15:0] addr;
        logic [7:0] wdata;
        logic write;
        region_t region;
        mapper_kind_t mapper;
        // Echoed back with the response
        logic [3:0] id;
    } stage_req_t;

endpackage

// ==== design/cart_stage_if.sv ====
interface cart_stage_if;
    import cart_pkg::*;

    logic valid;
    logic ready;
    stage_req_t req;
    // Filled in by the bank stage
    logic [15:0] phys_addr;

    modport source (
        output valid,
        output req,
        output phys_addr,
        input ready
    );

    modport sink (
        input valid,
        input req,
        input phys_addr,
        output ready
    );

endinterface

// ==== design/mapper_config.sv ====
`include "cart_consts.svh"

module mapper_config (
    input logic clk,
    input logic cpu_reset,
    input logic cfg_valid,
    input logic [3:0] cfg_addr,
    input logic [11:0] cfg_data,
    input logic vector_fetch,
    output cart_pkg::mapper_kind_t active_mapper,
    output logic chr_writable,
    output logic launcher_buffer,
    output logic [15:0] status
);
    import cart_pkg::*;

    mapper_kind_t committed_mapper;
    mapper_kind_t pending_mapper;
    logic load_pending;
    logic switching;

    // Switch on the reset-vector fetch itself, not the cycle after
    assign switching = load_pending && vector_fetch;
    assign active_mapper = switching ? pending_mapper : committed_mapper;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            committed_mapper <= MAP_LAUNCHER;
            pending_mapper <= MAP_LAUNCHER;
            load_pending <= 1'b0;
            chr_writable <= 1'b0;
            launcher_buffer <= 1'b0;
        end else begin
            if (cfg_valid && cfg_addr == `CART_CFG_MAPPER) begin
                pending_mapper <= mapper_kind_t'(cfg_data[1:0]);
                chr_writable <= cfg_data[2];
                load_pending <= 1'b1;
            end else if (cfg_valid && cfg_addr == `CART_CFG_LAUNCHER) begin
                launcher_buffer <= cfg_data[0];
            end

            if (switching) begin
                committed_mapper <= pending_mapper;
                load_pending <= 1'b0;
            end
        end
    end

    assign status = {
        11'd0,
        launcher_buffer,
        chr_writable,
        load_pending,
        committed_mapper
    };

    // The fetched mapper must be the committed one afterwards
    property p_switch_commits;
        @(posedge clk) disable iff (cpu_reset)
        switching |=> !load_pending && committed_mapper == $past(pending_mapper);
    endproperty
    a_switch_commits: assert property (p_switch_commits)
        else $error("mapper switch did not commit");

endmodule

// ==== design/bus_decode.sv ====
`include "cart_consts.svh"

module bus_decode (
    input logic clk,
    input logic cpu_reset,
    input logic req_valid,
    output logic req_ready,
    input cart_pkg::bus_space_t req_space,
    input logic [15:0] req_addr,
    input logic [7:0] req_wdata,
    input logic req_write,
    input logic [3:0] req_id,
    input cart_pkg::mapper_kind_t active_mapper,
    output logic vector_fetch,
    cart_stage_if.source out_if
);
    import cart_pkg::*;

    logic accept;
    logic out_valid;
    region_t region;
    stage_req_t out_req;

    assign req_ready = !out_valid || out_if.ready;
    assign accept = req_valid && req_ready;

    always_comb begin
        if (req_space == SPACE_CPU && req_addr[15]) begin
            region = REG_PRG;
        end else if (req_space == SPACE_CPU && req_addr[15:13] == 3'b011) begin
            region = REG_WRAM;
        end else if (req_space == SPACE_PPU && req_addr[15:13] == 3'b000) begin
            region = REG_CHR;
        end else begin
            region = REG_NONE;
        end
    end

    // CPU read of FFFC
    assign vector_fetch = accept && req_space == SPACE_CPU && !req_write
        && req_addr == `CART_RESET_VECTOR;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            out_valid <= 1'b0;
        end else if (req_ready) begin
            out_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_req.space <= req_space;
            out_req.addr <= req_addr;
            out_req.wdata <= req_wdata;
            out_req.write <= req_write;
            out_req.region <= region;
            out_req.mapper <= active_mapper;
            out_req.id <= req_id;
        end
    end

    assign out_if.valid = out_valid;
    assign out_if.req = out_req;
    // Raw bus address until the bank stage translates it
    assign out_if.phys_addr = out_req.addr;

    property p_hold_payload;
        @(posedge clk) disable iff (cpu_reset)
        out_if.valid && !out_if.ready |=> out_if.valid && $stable(out_if.req);
    endproperty
    a_hold_payload: assert property (p_hold_payload)
        else $error("decode payload changed while stalled");

endmodule

// ==== design/mapper_bank.sv ====
`include "cart_consts.svh"

module mapper_bank (
    input logic clk,
    input logic cpu_reset,
    input logic chr_writable,
    input logic launcher_buffer,
    cart_stage_if.sink in_if,
    cart_stage_if.source out_if
);
    import cart_pkg::*;

    logic [`CART_BANK_BITS-1:0] prg_bank;
    logic [`CART_BANK_BITS-1:0] chr_bank;
    mapper_kind_t last_mapper;

    logic accept;
    logic mapper_changed;
    logic [`CART_BANK_BITS-1:0] cur_prg;
    logic [`CART_BANK_BITS-1:0] cur_chr;
    logic prg_write;
    logic drop_write;
    logic [15:0] phys_next;

    logic out_valid;
    stage_req_t out_req;
    logic [15:0] out_phys;

    assign in_if.ready = !out_valid || out_if.ready;
    assign accept = in_if.valid && in_if.ready;

    // Banks read as zero for the first request under a new mapper
    assign mapper_changed = in_if.req.mapper != last_mapper;
    assign cur_prg = mapper_changed ? '0 : prg_bank;
    assign cur_chr = mapper_changed ? '0 : chr_bank;

    assign prg_write = in_if.req.write && in_if.req.region == REG_PRG;
    assign drop_write = (prg_write && in_if.req.mapper != MAP_LAUNCHER)
        || (in_if.req.write && in_if.req.region == REG_CHR
            && in_if.req.mapper != MAP_LAUNCHER && !chr_writable);

    always_comb begin
        phys_next = '0;
        case (in_if.req.region)
            REG_PRG: begin
                case (in_if.req.mapper)
                    MAP_LAUNCHER: phys_next = {launcher_buffer, in_if.req.addr[14:0]};
                    MAP_UXROM: begin
                        // C000-FFFF fixed to the last bank
                        if (in_if.req.addr[14]) begin
                            phys_next = {{`CART_BANK_BITS{1'b1}}, in_if.req.addr[13:0]};
                        end else begin
                            phys_next = {cur_prg, in_if.req.addr[13:0]};
                        end
                    end
                    default: phys_next = {1'b0, in_if.req.addr[14:0]};
                endcase
            end
            REG_CHR: begin
                if (in_if.req.mapper == MAP_CNROM) begin
                    phys_next = {{(16 - `CART_CHR_BITS){1'b0}}, cur_chr, in_if.req.addr[12:0]};
                end else begin
                    phys_next = {{(16 - `CART_CHR_BITS){1'b0}}, 2'b00, in_if.req.addr[12:0]};
                end
            end
            REG_WRAM: begin
                phys_next = {
                    {(16 - `CART_WRAM_BITS){1'b0}},
                    in_if.req.addr[`CART_WRAM_BITS-1:0]
                };
            end
            default: phys_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            out_valid <= 1'b0;
            prg_bank <= '0;
            chr_bank <= '0;
            last_mapper <= MAP_LAUNCHER;
        end else begin
            if (in_if.ready) begin
                out_valid <= in_if.valid;
            end
            if (accept) begin
                if (mapper_changed) begin
                    last_mapper <= in_if.req.mapper;
                    prg_bank <= '0;
                    chr_bank <= '0;
                end
                if (prg_write && in_if.req.mapper == MAP_UXROM) begin
                    prg_bank <= in_if.req.wdata[`CART_BANK_BITS-1:0];
                end
                if (prg_write && in_if.req.mapper == MAP_CNROM) begin
                    chr_bank <= in_if.req.wdata[`CART_BANK_BITS-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_req <= in_if.req;
            // Swallowed writes still get a response, but touch no memory
            if (drop_write) begin
                out_req.region <= REG_NONE;
            end
            out_phys <= phys_next;
        end
    end

    assign out_if.valid = out_valid;
    assign out_if.req = out_req;
    assign out_if.phys_addr = out_phys;

endmodule

// ==== design/cart_memory.sv ====
`include "cart_consts.svh"

module cart_memory (
    input logic clk,
    input logic cpu_reset,
    input logic rsp_ready,
    cart_stage_if.sink in_if,
    output logic rsp_valid,
    output logic [7:0] rsp_rdata,
    output logic [3:0] rsp_id
);
    import cart_pkg::*;

    logic [7:0] prg_mem[2**`CART_PRG_BITS];
    logic [7:0] chr_mem[2**`CART_CHR_BITS];
    logic [7:0] wram_mem[2**`CART_WRAM_BITS];

    logic accept;
    logic do_write;
    logic [7:0] rdata_next;

    assign in_if.ready = !rsp_valid || rsp_ready;
    assign accept = in_if.valid && in_if.ready;
    assign do_write = accept && in_if.req.write && in_if.req.region != REG_NONE;

    always_ff @(posedge clk) begin
        if (do_write) begin
            case (in_if.req.region)
                REG_PRG: prg_mem[in_if.phys_addr[`CART_PRG_BITS-1:0]] <= in_if.req.wdata;
                REG_CHR: chr_mem[in_if.phys_addr[`CART_CHR_BITS-1:0]] <= in_if.req.wdata;
                REG_WRAM: wram_mem[in_if.phys_addr[`CART_WRAM_BITS-1:0]] <= in_if.req.wdata;
                default: ;
            endcase
        end
    end

    // Writes answer 00, unmapped reads FF
    always_comb begin
        if (in_if.req.write) begin
            rdata_next = 8'h00;
        end else begin
            case (in_if.req.region)
                REG_PRG: rdata_next = prg_mem[in_if.phys_addr[`CART_PRG_BITS-1:0]];
                REG_CHR: rdata_next = chr_mem[in_if.phys_addr[`CART_CHR_BITS-1:0]];
                REG_WRAM: rdata_next = wram_mem[in_if.phys_addr[`CART_WRAM_BITS-1:0]];
                default: rdata_next = 8'hFF;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            rsp_valid <= 1'b0;
        end else if (in_if.ready) begin
            rsp_valid <= in_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_rdata <= rdata_next;
            rsp_id <= in_if.req.id;
        end
    end

    // A response only follows a request taken outside reset
    property p_rsp_after_reset;
        @(posedge clk)
        $rose(rsp_valid) |-> !$past(cpu_reset) && $past(in_if.valid);
    endproperty
    a_rsp_after_reset: assert property (p_rsp_after_reset)
        else $error("response raised during reset");

endmodule

// ==== design/cart_top.sv ====
module cart_top (
    input logic clk,
    input logic cpu_reset,

    input logic req_valid,
    output logic req_ready,
    input cart_pkg::bus_space_t req_space,
    input logic [15:0] req_addr,
    input logic [7:0] req_wdata,
    input logic req_write,
    input logic [3:0] req_id,

    output logic rsp_valid,
    input logic rsp_ready,
    output logic [7:0] rsp_rdata,
    output logic [3:0] rsp_id,

    input logic cfg_valid,
    input logic [3:0] cfg_addr,
    input logic [11:0] cfg_data,

    output logic [15:0] status
);
    import cart_pkg::*;

    mapper_kind_t active_mapper;
    logic vector_fetch;
    logic chr_writable;
    logic launcher_buffer;

    cart_stage_if dec_to_bank ();
    cart_stage_if bank_to_mem ();

    mapper_config config0 (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .cfg_valid(cfg_valid),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .vector_fetch(vector_fetch),
        .active_mapper(active_mapper),
        .chr_writable(chr_writable),
        .launcher_buffer(launcher_buffer),
        .status(status)
    );

    bus_decode decode0 (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_space(req_space),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .req_write(req_write),
        .req_id(req_id),
        .active_mapper(active_mapper),
        .vector_fetch(vector_fetch),
        .out_if(dec_to_bank.source)
    );

    mapper_bank bank0 (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .chr_writable(chr_writable),
        .launcher_buffer(launcher_buffer),
        .in_if(dec_to_bank.sink),
        .out_if(bank_to_mem.source)
    );

    cart_memory memory0 (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .rsp_ready(rsp_ready),
        .in_if(bank_to_mem.sink),
        .rsp_valid(rsp_valid),
        .rsp_rdata(rsp_rdata),
        .rsp_id(rsp_id)
    );

endmodule

// ==== testbench/cart_model.svh ====
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

// Reference state of the mapper subsystem
mapper_kind_t m_committed = MAP_LAUNCHER;
mapper_kind_t m_pending = MAP_LAUNCHER;
mapper_kind_t m_last = MAP_LAUNCHER;
logic m_load_pending = 1'b0;
logic m_chr_wr = 1'b0;
logic m_buf = 1'b0;
logic [1:0] m_prg_bank = 2'd0;
logic [1:0] m_chr_bank = 2'd0;

// Only written bytes are known
logic [7:0] prg_model[int];
logic [7:0] chr_model[int];
logic [7:0] wram_model[int];

function automatic void apply_config(input logic [3:0] addr, input logic [11:0] data);
    if (addr == `CART_CFG_MAPPER) begin
        m_pending = mapper_kind_t'(data[1:0]);
        m_chr_wr = data[2];
        m_load_pending = 1'b1;
    end else if (addr == `CART_CFG_LAUNCHER) begin
        m_buf = data[0];
    end
endfunction

function automatic region_t region_of(input bus_space_t space, input logic [15:0] addr);
    if (space == SPACE_CPU && addr >= 16'h8000) begin
        return REG_PRG;
    end
    if (space == SPACE_CPU && addr >= 16'h6000) begin
        return REG_WRAM;
    end
    if (space == SPACE_PPU && addr < 16'h2000) begin
        return REG_CHR;
    end
    return REG_NONE;
endfunction

function automatic void predict_access(input bus_space_t space, input logic [15:0] addr,
        input logic [7:0] wdata, input logic write,
        output logic [7:0] rdata, output logic known);
    region_t rgn;
    mapper_kind_t mapper;
    int phys;
    rgn = region_of(space, addr);
    mapper = m_committed;
    rdata = 8'h00;
    known = 1'b1;
    if (m_load_pending && space == SPACE_CPU && !write && addr == `CART_RESET_VECTOR) begin
        mapper = m_pending;
        m_committed = m_pending;
        m_load_pending = 1'b0;
    end
    if (mapper != m_last) begin
        m_last = mapper;
        m_prg_bank = 2'd0;
        m_chr_bank = 2'd0;
    end
    case (rgn)
        REG_PRG: begin
            if (write && mapper != MAP_LAUNCHER) begin
                if (mapper == MAP_UXROM) m_prg_bank = wdata[1:0];
                if (mapper == MAP_CNROM) m_chr_bank = wdata[1:0];
                return;
            end
            if (mapper == MAP_LAUNCHER) begin
                phys = int'(m_buf) * 32768 + int'(addr[14:0]);
            end else if (mapper == MAP_UXROM) begin
                phys = (addr[14] ? 3 : int'(m_prg_bank)) * 16384 + int'(addr[13:0]);
            end else begin
                phys = int'(addr[14:0]);
            end
            if (write) prg_model[phys] = wdata;
            else if (prg_model.exists(phys)) rdata = prg_model[phys];
            else known = 1'b0;
        end
        REG_CHR: begin
            phys = (mapper == MAP_CNROM ? int'(m_chr_bank) * 8192 : 0) + int'(addr[12:0]);
            if (write) begin
                if (mapper == MAP_LAUNCHER || m_chr_wr) chr_model[phys] = wdata;
            end else if (chr_model.exists(phys)) rdata = chr_model[phys];
            else known = 1'b0;
        end
        REG_WRAM: begin
            phys = int'(addr[12:0]);
            if (write) wram_model[phys] = wdata;
            else if (wram_model.exists(phys)) rdata = wram_model[phys];
            else known = 1'b0;
        end
        default: rdata = write ? 8'h00 : 8'hFF;
    endcase
endfunction

`endif

// ==== testbench/cart_tb.sv ====
`include "cart_consts.svh"

module cart_tb;
    import cart_pkg::*;

    `include "cart_model.svh"

    localparam int N_OFFS = 8;
    localparam int N_CHR = 16;
    localparam int N_BANKW = 8;
    localparam int N_CHR4 = 4;
    localparam int N_WRAM = 16;
    localparam int N_UNMAP = 4;
    localparam int N_BP = 64;
    localparam int TOTAL_REQ = 8 * N_OFFS + 2 * N_CHR + 7 + 1 + 3 * N_BANKW + 4
        + 2 * (1 + 4 * (1 + 2 * N_CHR4)) + 3 + 2 * N_WRAM + 2 * N_UNMAP + N_BP;
    localparam int CYCLE_LIMIT = 20 * TOTAL_REQ + 200;

    logic clk;
    logic cpu_reset;
    logic req_valid;
    logic req_ready;
    bus_space_t req_space;
    logic [15:0] req_addr;
    logic [7:0] req_wdata;
    logic req_write;
    logic [3:0] req_id;
    logic rsp_valid;
    logic rsp_ready;
    logic [7:0] rsp_rdata;
    logic [3:0] rsp_id;
    logic cfg_valid;
    logic [3:0] cfg_addr;
    logic [11:0] cfg_data;
    logic [15:0] status;

    logic [7:0] exp_data[$];
    logic [3:0] exp_id[$];
    logic exp_known[$];

    logic [13:0] prg_offs[N_OFFS];
    logic [12:0] chr_addrs[N_CHR];
    logic [12:0] chr4_offs[N_CHR4];
    logic [12:0] wram_addrs[N_WRAM];

    logic stall_en = 1'b0;
    logic [3:0] next_id = 4'd0;
    int cycles = 0;
    int test_num = 1;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    cart_top dut0 (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_space(req_space),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .req_write(req_write),
        .req_id(req_id),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_rdata(rsp_rdata),
        .rsp_id(rsp_id),
        .cfg_valid(cfg_valid),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .status(status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with responses outstanding", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Random response back-pressure
    always @(posedge clk) begin
        #10;
        rsp_ready = stall_en ? ($urandom_range(3) != 0) : 1'b1;
    end

    always @(negedge clk) begin
        if (!cpu_reset && rsp_valid && rsp_ready) begin
            if (exp_id.size() == 0) begin
                $display("Response arrived with no request outstanding");
                test_errors++;
            end else begin
                if (rsp_id !== exp_id[0]) begin
                    $display("Fail rsp_id got %h expected %h", rsp_id, exp_id[0]);
                    test_errors++;
                end else if (exp_known[0] && rsp_rdata !== exp_data[0]) begin
                    $display("Fail rsp_rdata id %h got %h expected %h",
                        rsp_id, rsp_rdata, exp_data[0]);
                    test_errors++;
                end
                exp_id.delete(0);
                exp_data.delete(0);
                exp_known.delete(0);
            end
        end
    end

    task automatic configure(input logic [3:0] addr, input logic [11:0] data);
        apply_config(addr, data);
        cfg_valid = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        @(posedge clk);
        #10;
        cfg_valid = 1'b0;
    endtask

    task automatic send(input bus_space_t space, input logic [15:0] addr,
            input logic [7:0] wdata, input logic write);
        logic [7:0] rdata;
        logic known;
        logic taken;
        predict_access(space, addr, wdata, write, rdata, known);
        exp_data.push_back(rdata);
        exp_id.push_back(next_id);
        exp_known.push_back(known);
        req_valid = 1'b1;
        req_space = space;
        req_addr = addr;
        req_wdata = wdata;
        req_write = write;
        req_id = next_id;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
        end
        #10;
        req_valid = 1'b0;
        next_id = next_id + 4'd1;
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        send(SPACE_CPU, addr, data, 1'b1);
    endtask

    task automatic cpu_read(input logic [15:0] addr);
        send(SPACE_CPU, addr, 8'h00, 1'b0);
    endtask

    task automatic ppu_write(input logic [15:0] addr, input logic [7:0] data);
        send(SPACE_PPU, addr, data, 1'b1);
    endtask

    task automatic ppu_read(input logic [15:0] addr);
        send(SPACE_PPU, addr, 8'h00, 1'b0);
    endtask

    // Program the mapper, then fetch the reset vector to switch
    task automatic switch_mapper(input logic [11:0] data);
        configure(`CART_CFG_MAPPER, data);
        cpu_read(`CART_RESET_VECTOR);
    endtask

    task automatic drain();
        if (exp_id.size() != 0) begin
            while (exp_id.size() != 0) @(posedge clk);
            #10;
        end
    endtask

    task automatic finish_test(input string name);
        drain();
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", test_num, name, test_errors);
        end
        test_num++;
        test_errors = 0;
    endtask

    initial begin
        logic [15:0] exp_status;
        logic [1:0] bank;
        int kind;
        void'($urandom(32'h0460_2ac9));
        cpu_reset = 1'b1;
        req_valid = 1'b0;
        req_space = SPACE_CPU;
        req_addr = 16'h0000;
        req_wdata = 8'h00;
        req_write = 1'b0;
        req_id = 4'd0;
        rsp_ready = 1'b1;
        cfg_valid = 1'b0;
        cfg_addr = 4'd0;
        cfg_data = 12'd0;
        for (int i = 0; i < N_OFFS; i++) prg_offs[i] = 14'($urandom);
        for (int i = 0; i < N_CHR; i++) chr_addrs[i] = 13'($urandom);
        for (int i = 0; i < N_CHR4; i++) chr4_offs[i] = 13'($urandom);
        for (int i = 0; i < N_WRAM; i++) wram_addrs[i] = 13'($urandom);
        repeat (2) @(posedge clk);
        #10;
        cpu_reset = 1'b0;

        // Launcher fills all four PRG banks through both buffers
        for (int b = 0; b < 4; b++) begin
            configure(`CART_CFG_LAUNCHER, {11'd0, b[1]});
            for (int i = 0; i < N_OFFS; i++) begin
                cpu_write({1'b1, b[0], prg_offs[i]}, 8'($urandom));
            end
            for (int i = 0; i < N_OFFS; i++) cpu_read({1'b1, b[0], prg_offs[i]});
        end
        for (int i = 0; i < N_CHR; i++) ppu_write({3'b000, chr_addrs[i]}, 8'($urandom));
        for (int i = 0; i < N_CHR; i++) ppu_read({3'b000, chr_addrs[i]});
        finish_test("launcher load");

        configure(`CART_CFG_LAUNCHER, 12'd0);
        cpu_write(16'h8000, 8'($urandom));
        cpu_write(16'hFFFC, 8'($urandom));
        configure(`CART_CFG_LAUNCHER, 12'd1);
        cpu_write(16'h8000, 8'($urandom));
        cpu_write(16'hFFFC, 8'($urandom));
        configure(`CART_CFG_MAPPER, {10'd0, MAP_NROM});
        // Still the launcher mapping until the vector fetch
        cpu_read(16'h8000);
        cpu_read(`CART_RESET_VECTOR);
        cpu_read(16'h8000);
        drain();
        exp_status = {11'd0, m_buf, m_chr_wr, m_load_pending, m_committed};
        if (status !== exp_status) begin
            $display("Fail status got %h expected %h", status, exp_status);
            test_errors++;
        end
        finish_test("NROM switch");

        switch_mapper({10'd0, MAP_UXROM});
        for (int i = 0; i < N_BANKW; i++) begin
            cpu_write(16'h8000, 8'($urandom));
            cpu_read({2'b10, prg_offs[$urandom_range(N_OFFS - 1)]});
            cpu_read({2'b11, prg_offs[$urandom_range(N_OFFS - 1)]});
        end
        // Another mapper in between clears the bank register
        cpu_write(16'h8000, 8'h03);
        switch_mapper({10'd0, MAP_NROM});
        switch_mapper({10'd0, MAP_UXROM});
        cpu_read({2'b10, prg_offs[0]});
        finish_test("UxROM banking");

        switch_mapper({9'd0, 1'b1, MAP_CNROM});
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1) switch_mapper({9'd0, 1'b0, MAP_CNROM});
            for (int b = 0; b < 4; b++) begin
                bank = 2'(b);
                cpu_write(16'h8000, {6'd0, bank});
                for (int i = 0; i < N_CHR4; i++) ppu_write({3'b000, chr4_offs[i]}, 8'($urandom));
                for (int i = 0; i < N_CHR4; i++) ppu_read({3'b000, chr4_offs[i]});
            end
        end
        // Detour through NROM drops the CHR bank back to 0
        switch_mapper({10'd0, MAP_NROM});
        switch_mapper({10'd0, MAP_CNROM});
        ppu_read({3'b000, chr4_offs[0]});
        finish_test("CNROM CHR banking");

        stall_en = 1'b1;
        for (int i = 0; i < N_WRAM; i++) cpu_write({3'b011, wram_addrs[i]}, 8'($urandom));
        for (int i = 0; i < N_WRAM; i++) cpu_read({3'b011, wram_addrs[i]});
        for (int i = 0; i < N_UNMAP; i++) begin
            cpu_read({3'b010, 13'($urandom)});
            cpu_write({3'b010, 13'($urandom)}, 8'($urandom));
        end
        finish_test("WRAM and unmapped");

        for (int i = 0; i < N_BP; i++) begin
            kind = int'($urandom_range(3));
            case (kind)
                0: cpu_write({3'b011, wram_addrs[$urandom_range(N_WRAM - 1)]}, 8'($urandom));
                1: cpu_read({3'b011, wram_addrs[$urandom_range(N_WRAM - 1)]});
                2: cpu_read({2'b10, prg_offs[$urandom_range(N_OFFS - 1)]});
                default: cpu_read({3'b010, 13'($urandom)});
            endcase
        end
        finish_test("back-pressure");
        stall_en = 1'b0;

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+design
+incdir+testbench
design/cart_pkg.sv
design/cart_stage_if.sv
design/mapper_config.sv
design/bus_decode.sv
design/mapper_bank.sv
design/cart_memory.sv
design/cart_top.sv
testbench/cart_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = cart_tb
FILELIST = files.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
